// File: logic/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

`define MEM_LINE_BITS 256 // One cache line
`define MEM_ADDR_BITS 32 // Byte address

`define MEM_LINES 64
`define MEM_LATENCY 4 // Cycles per access, 1 or more

// Byte address split into offset, line index and aliased upper bits
`define MEM_LINE_BYTES (`MEM_LINE_BITS / 8)
`define MEM_OFFSET_BITS $clog2(`MEM_LINE_BYTES)
`define MEM_INDEX_BITS $clog2(`MEM_LINES)
`define MEM_INDEX_LSB `MEM_OFFSET_BITS

// Wide enough to count up to the latency itself
`define MEM_COUNT_BITS $clog2(`MEM_LATENCY + 1)

`endif

// File: logic/mem_pkg.sv
package mem_pkg;

	`include "mem_settings.svh"

	// Byte address as the core issues it
	typedef logic [`MEM_ADDR_BITS-1:0] rv32i_word;

	// Whole line moved on every transfer
	typedef logic [`MEM_LINE_BITS-1:0] cache_line;

	// Request side of a line port, held until resp
	typedef struct packed {
		logic read; // Level
		logic write; // Level
		rv32i_word address;
		cache_line wdata;
	} line_req;

	// Response side of a line port
	typedef struct packed {
		logic resp; // Single-cycle pulse
		cache_line rdata; // Valid while resp is high
	} line_rsp;

endpackage : mem_pkg

// File: logic/line_arbiter.sv
`timescale 1ns/10ps

module line_arbiter (
	input logic clk,
	input logic rst,

	input mem_pkg::line_req icache_req,
	output mem_pkg::line_rsp icache_rsp,

	input mem_pkg::line_req dcache_req,
	output mem_pkg::line_rsp dcache_rsp,

	output mem_pkg::line_req pmem_req,
	input mem_pkg::line_rsp pmem_rsp
);

	typedef enum logic [2:0] {
		st_idle,
		st_grant_iread,
		st_grant_dread,
		st_grant_dwrite,
		st_reading,
		st_writing,
		st_finish
	} arb_state_e;

	arb_state_e state;
	arb_state_e next_state;

	// Datapath registers
	mem_pkg::rv32i_word addr_q;
	mem_pkg::cache_line wdata_q;
	mem_pkg::cache_line rdata_q;
	logic owner_q; // 0 icache, 1 dcache

	// Address source and requester identity for the grant cycle
	logic sel_dcache;
	mem_pkg::rv32i_word addr_mux;

	// State-decoded controls
	logic load_addr;
	logic load_wdata;
	logic load_rdata;
	logic load_owner;
	logic pmem_read;
	logic pmem_write;
	logic finish_resp;

	always_comb begin
		addr_mux = sel_dcache ? dcache_req.address : icache_req.address;
	end

	always_comb begin
		sel_dcache = 1'b0;
		load_addr = 1'b0;
		load_wdata = 1'b0;
		load_rdata = 1'b0;
		load_owner = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		finish_resp = 1'b0;

		case (state)
			st_grant_iread: begin
				sel_dcache = 1'b0;
				load_addr = 1'b1;
				load_owner = 1'b1;
			end
			st_grant_dread: begin
				sel_dcache = 1'b1;
				load_addr = 1'b1;
				load_owner = 1'b1;
			end
			st_grant_dwrite: begin
				sel_dcache = 1'b1;
				load_addr = 1'b1;
				load_wdata = 1'b1;
				load_owner = 1'b1;
			end
			st_reading: begin
				pmem_read = 1'b1;
				load_rdata = 1'b1; // Last load is the resp cycle
			end
			st_writing: begin
				pmem_write = 1'b1;
			end
			st_finish: begin
				finish_resp = 1'b1;
			end
			default: ;
		endcase
	end

	// Fixed priority, icache write bit is never looked at
	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (icache_req.read) begin
					next_state = st_grant_iread;
				end else if (dcache_req.read) begin
					next_state = st_grant_dread;
				end else if (dcache_req.write) begin
					next_state = st_grant_dwrite;
				end
			end
			st_grant_iread: next_state = st_reading;
			st_grant_dread: next_state = st_reading;
			st_grant_dwrite: next_state = st_writing;
			st_reading: begin
				if (pmem_rsp.resp) next_state = st_finish;
			end
			st_writing: begin
				if (pmem_rsp.resp) next_state = st_finish;
			end
			st_finish: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (load_addr) addr_q <= addr_mux;
		if (load_owner) owner_q <= sel_dcache;
	end

	always_ff @(posedge clk) begin
		if (load_wdata) wdata_q <= dcache_req.wdata;
		if (load_rdata) rdata_q <= pmem_rsp.rdata;
	end

	always_comb begin
		pmem_req.read = pmem_read;
		pmem_req.write = pmem_write;
		pmem_req.address = addr_q;
		pmem_req.wdata = wdata_q;
	end

	// Only the owner sees the pulse, both see the data
	always_comb begin
		icache_rsp.resp = finish_resp & ~owner_q;
		icache_rsp.rdata = rdata_q;
		dcache_rsp.resp = finish_resp & owner_q;
		dcache_rsp.rdata = rdata_q;
	end

endmodule : line_arbiter

// File: logic/line_memory.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module line_memory (
	input logic clk,
	input logic rst,

	input mem_pkg::line_req req,
	output mem_pkg::line_rsp rsp
);

	localparam int COUNT_BITS = `MEM_COUNT_BITS;
	localparam int INDEX_BITS = `MEM_INDEX_BITS;
	localparam int INDEX_LSB = `MEM_INDEX_LSB;
	localparam logic [COUNT_BITS-1:0] LAST_COUNT = COUNT_BITS'(`MEM_LATENCY - 1);

	mem_pkg::cache_line lines [`MEM_LINES];

	logic [COUNT_BITS-1:0] count;
	logic [COUNT_BITS-1:0] count_next;
	logic [INDEX_BITS-1:0] index;
	logic active;
	logic done;

	// Offset bits are dropped and upper bits alias onto the same lines
	always_comb begin
		index = req.address[INDEX_LSB +: INDEX_BITS];
	end

	always_comb begin
		active = req.read | req.write;
		done = active && (count == LAST_COUNT); // Latency-th held cycle
	end

	// Restart when the request drops and after each answer
	always_comb begin
		if (!active || done) begin
			count_next = '0;
		end else begin
			count_next = count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MEM_LINES; i++) begin
				lines[i] <= '0;
			end
		end else if (done && req.write) begin
			lines[index] <= req.wdata; // Committed in the resp cycle
		end
	end

	always_comb begin
		rsp.resp = done;
		rsp.rdata = lines[index];
	end

endmodule : line_memory

// File: logic/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top (
	input logic clk,
	input logic rst,

	// Instruction cache port, read only
	input mem_pkg::line_req icache_req,
	output mem_pkg::line_rsp icache_rsp,

	// Data cache port
	input mem_pkg::line_req dcache_req,
	output mem_pkg::line_rsp dcache_rsp
);

	// Shared physical memory port
	mem_pkg::line_req pmem_req;
	mem_pkg::line_rsp pmem_rsp;

	line_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.icache_req(icache_req),
		.icache_rsp(icache_rsp),
		.dcache_req(dcache_req),
		.dcache_rsp(dcache_rsp),
		.pmem_req(pmem_req),
		.pmem_rsp(pmem_rsp)
	);

	line_memory u_memory (
		.clk(clk),
		.rst(rst),
		.req(pmem_req),
		.rsp(pmem_rsp)
	);

endmodule : mem_subsystem_top

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2) clk = ~clk; // Starts low, first rising edge at half a period
	end

endmodule : tb_clock_gen

// File: verification/tb_mem_subsystem.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module tb_mem_subsystem;

	localparam int CLK_PERIOD_NS = 40;
	localparam int MIX_OPS = 200;
	localparam int TOTAL_OPS = 3 + 8 + 4 + 3 + MIX_OPS;
	localparam int WATCHDOG_NS = TOTAL_OPS * (`MEM_LATENCY + 4) * 2 * CLK_PERIOD_NS;

	logic clk;
	logic rst;
	mem_pkg::line_req icache_req;
	mem_pkg::line_rsp icache_rsp;
	mem_pkg::line_req dcache_req;
	mem_pkg::line_rsp dcache_rsp;

	mem_pkg::cache_line model [`MEM_LINES]; // Expected memory contents
	integer seed;
	int cycle;
	int errors;
	int checks;
	int test_start_errors;
	int tests_passed;
	int tests_failed;
	int icache_pulses;
	int dcache_pulses;
	int icache_done_cycle;
	int dcache_done_cycle;
	string test_name;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk(clk));

	mem_subsystem_top uut (
		.clk(clk),
		.rst(rst),
		.icache_req(icache_req),
		.icache_rsp(icache_rsp),
		.dcache_req(dcache_req),
		.dcache_rsp(dcache_rsp)
	);

	// Bits 10 to 5 pick the line, offset and upper bits alias
	function automatic int line_index(input mem_pkg::rv32i_word addr);
		return int'(addr[10:5]);
	endfunction

	task automatic random_line(output mem_pkg::cache_line data);
		for (int i = 0; i < `MEM_LINE_BITS / 32; i++) begin
			data[i*32 +: 32] = $random(seed);
		end
	endtask

	task automatic check_line(input string name, input mem_pkg::cache_line expected,
			input mem_pkg::cache_line actual);
		checks++;
		assert (actual === expected) else begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	// Called one cycle after resp was seen
	task automatic check_pulse_ended(input string name, input logic resp);
		checks++;
		assert (!resp) else begin
			$display("%s: resp stayed high for more than one cycle", name);
			errors++;
		end
	endtask

	task automatic icache_read(input mem_pkg::rv32i_word addr, input string name);
		mem_pkg::cache_line actual;
		@(negedge clk);
		icache_req.read = 1'b1;
		icache_req.write = 1'b0;
		icache_req.address = addr;
		do @(negedge clk); while (!icache_rsp.resp);
		icache_done_cycle = cycle;
		actual = icache_rsp.rdata;
		check_line(name, model[line_index(addr)], actual);
		@(negedge clk);
		icache_req.read = 1'b0;
		check_pulse_ended(name, icache_rsp.resp);
	endtask

	task automatic dcache_access(input logic is_write, input mem_pkg::rv32i_word addr,
			input mem_pkg::cache_line data, input string name);
		@(negedge clk);
		dcache_req.read = !is_write;
		dcache_req.write = is_write;
		dcache_req.address = addr;
		dcache_req.wdata = data;
		do @(negedge clk); while (!dcache_rsp.resp);
		dcache_done_cycle = cycle;
		if (is_write) begin
			model[line_index(addr)] = data; // Written once its resp is seen
		end else begin
			check_line(name, model[line_index(addr)], dcache_rsp.rdata);
		end
		@(negedge clk);
		dcache_req.read = 1'b0;
		dcache_req.write = 1'b0;
		check_pulse_ended(name, dcache_rsp.resp);
	endtask

	task automatic check_quiet(input string name);
		checks++;
		assert (!icache_rsp.resp && !dcache_rsp.resp) else begin
			$display("%s: a resp bit went high with no request pending", name);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		if (errors == test_start_errors) begin
			tests_passed++;
			$display("Test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	always @(posedge clk) begin
		cycle++;
	end

	// A resp may only reach a port that is holding a request
	always @(negedge clk) begin
		if (!rst) begin
			if (icache_rsp.resp) icache_pulses++;
			if (dcache_rsp.resp) dcache_pulses++;
			assert (!icache_rsp.resp || icache_req.read) else begin
				$display("%s: icache resp pulsed without an icache request", test_name);
				errors++;
			end
			assert (!dcache_rsp.resp || dcache_req.read || dcache_req.write) else begin
				$display("%s: dcache resp pulsed without a dcache request", test_name);
				errors++;
			end
			assert (!(icache_rsp.resp && dcache_rsp.resp)) else begin
				$display("%s: both resp bits were high in the same cycle", test_name);
				errors++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: a response from the memory subsystem never came");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		mem_pkg::rv32i_word addr_a;
		mem_pkg::rv32i_word addr_b;
		mem_pkg::cache_line data;
		mem_pkg::rv32i_word fetch_addrs [4];
		int n;
		int icache_before;
		int dcache_before;
		logic is_write;

		rst = 1'b1;
		icache_req = '0;
		dcache_req = '0;
		seed = 71386;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests_passed = 0;
		tests_failed = 0;
		icache_pulses = 0;
		dcache_pulses = 0;
		for (int i = 0; i < `MEM_LINES; i++) begin
			model[i] = '0;
		end

		begin_test("reset_quiet");
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check_quiet(test_name);
		end
		rst = 1'b0; // Three rising edges seen with rst high
		repeat (4) begin
			@(negedge clk);
			check_quiet(test_name);
		end
		finish_test();

		begin_test("write_read_back");
		addr_a = $random(seed);
		addr_a[10:5] = 6'd1;
		random_line(data);
		dcache_access(1'b1, addr_a, data, test_name);
		dcache_access(1'b0, addr_a, '0, test_name);
		dcache_access(1'b0, 32'h0000_07e0, '0, test_name); // Line 63, still zero
		finish_test();

		begin_test("instruction_fetch");
		for (int i = 0; i < 4; i++) begin
			fetch_addrs[i] = $random(seed);
			random_line(data);
			dcache_access(1'b1, fetch_addrs[i], data, test_name);
		end
		icache_before = icache_pulses;
		dcache_before = dcache_pulses;
		for (int i = 0; i < 4; i++) begin
			icache_read(fetch_addrs[i], test_name);
		end
		check_count(test_name, icache_before + 4, icache_pulses);
		check_count(test_name, dcache_before, dcache_pulses);
		finish_test();

		begin_test("priority");
		addr_a = $random(seed);
		random_line(data);
		dcache_access(1'b1, addr_a, data, test_name);
		random_line(data);
		fork
			icache_read(addr_a, test_name); // Must still see the old line
			dcache_access(1'b1, addr_a, data, test_name);
		join
		checks++;
		assert (icache_done_cycle < dcache_done_cycle) else begin
			$display("%s: dcache resp came before the icache resp", test_name);
			errors++;
		end
		dcache_access(1'b0, addr_a, '0, test_name);
		finish_test();

		begin_test("offset_alias");
		addr_a = $random(seed);
		random_line(data);
		dcache_access(1'b1, addr_a, data, test_name);
		dcache_access(1'b0, addr_a ^ 32'h0000_001f, '0, test_name);
		icache_read(addr_a ^ 32'hffff_f800, test_name);
		finish_test();

		begin_test("random_mix");
		n = 0;
		while (n < MIX_OPS) begin
			addr_a = $random(seed);
			addr_b = $random(seed);
			random_line(data);
			is_write = ({$random(seed)} % 2) == 1;
			if (n < MIX_OPS - 1 && ({$random(seed)} % 4) == 0) begin
				fork
					icache_read(addr_a, test_name);
					dcache_access(is_write, addr_b, data, test_name);
				join
				n += 2;
			end else begin
				case ({$random(seed)} % 3)
					0: icache_read(addr_a, test_name);
					1: dcache_access(1'b0, addr_a, '0, test_name);
					default: dcache_access(1'b1, addr_a, data, test_name);
				endcase
				n += 1;
			end
		end
		finish_test();

		$display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_passed, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : tb_mem_subsystem

// File: vlog.f
+incdir+logic
logic/mem_pkg.sv
logic/line_arbiter.sv
logic/line_memory.sv
logic/mem_subsystem_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f \
	--top-module tb_mem_subsystem -Mdir obj_dir -o tb_mem_subsystem \
	&& ./obj_dir/tb_mem_subsystem > sim.log 2>&1 \
	|| echo "Build or simulation run ended with an error"

[ -f sim.log ] && cat sim.log

grep -q "^Simulation PASSED$" sim.log \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
